// ==== rtl/rob_pkg.sv ====
package rob_pkg;

    // R-type view of an instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    // S/B-type view, the rd slot carries immediate bits
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } instr_sb_t;

    typedef union packed {
        instr_r_t  r;
        instr_sb_t sb;
    } instr_word_u;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        rd_we;
        logic        done;   // Result has been written back
        logic [31:0] result;
    } rob_entry_t;

    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [31:0] APB_ADDR_STATUS  = 32'h0;
    localparam logic [31:0] APB_ADDR_COMMITS = 32'h4;

    // Tag indexes one ROB slot
    function automatic int tag_w(input int depth);
        return (depth > 1) ? $clog2(depth) : 1;
    endfunction

endpackage

// ==== rtl/rob_wb_if.sv ====
`timescale 1ns/1ps

interface rob_wb_if #(
    parameter int WB_PORTS = 2,
    parameter int DEPTH    = 8
);
    localparam int TW = rob_pkg::tag_w(DEPTH);

    logic [WB_PORTS-1:0] valid;
    logic [TW-1:0]       tag    [WB_PORTS];   // Slot being written back
    logic [31:0]         result [WB_PORTS];

    modport source (output valid, tag, result);
    modport sink   (input valid, tag, result);

endinterface

// ==== rtl/circular_queue.sv ====
`timescale 1ns/1ps

module circular_queue #(
    parameter int SS      = 2,
    parameter int DEPTH   = 8,
    parameter int SEL_OUT = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  logic                       pop,
    input  rob_pkg::rob_entry_t        in      [SS],
    rob_wb_if.sink                     wb,
    input  logic [$clog2(DEPTH)-1:0]   obs_sel [SEL_OUT],
    output logic                       empty,
    output logic                       full,
    output logic [$clog2(DEPTH)-1:0]   head_out,
    output logic [$clog2(DEPTH)-1:0]   tail_out,
    output logic [$clog2(DEPTH):0]     count,
    output rob_pkg::rob_entry_t        out     [SS],
    output rob_pkg::rob_entry_t        obs_out [SEL_OUT]
);
    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] STEP = (AW + 1)'(SS);

    rob_pkg::rob_entry_t entries [DEPTH];

    logic [AW:0]   head, tail;   // Extra top bit tells full from empty
    logic [AW:0]   head_spec;
    logic [AW-1:0] wb_off;
    logic          wb_bad;

    assign head_out  = head[AW-1:0];
    assign tail_out  = tail[AW-1:0];
    assign head_spec = head + STEP;
    assign empty     = (head == tail);
    assign count     = head - tail;

    // Speculative full: no room left for another whole group
    assign full = (head_spec[AW-1:0] == tail[AW-1:0]) && (head_spec[AW] != tail[AW]);

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (push)
                head <= head + STEP;
            if (pop)
                tail <= tail + STEP;
        end
    end

    // Group write first, writebacks after so they win on a shared slot
    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < SS; i++)
                entries[head_out + AW'(i)] <= in[i];
        end
        for (int i = 0; i < $size(wb.valid); i++) begin
            if (wb.valid[i]) begin
                entries[wb.tag[i]].done   <= 1'b1;
                entries[wb.tag[i]].result <= wb.result[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < SS; i++)
                out[i] <= '0;
        end else if (pop) begin
            for (int i = 0; i < SS; i++)
                out[i] <= entries[tail_out + AW'(i)];   // Oldest group
        end
    end

    always_comb begin
        for (int i = 0; i < SEL_OUT; i++)
            obs_out[i] = entries[obs_sel[i]];
    end

    // A writeback must land on a live entry that is still pending
    always_comb begin
        wb_bad = 1'b0;
        wb_off = '0;
        for (int i = 0; i < $size(wb.valid); i++) begin
            if (wb.valid[i]) begin
                wb_off = wb.tag[i] - tail_out;
                if ((AW + 1)'(wb_off) >= count || entries[wb.tag[i]].done)
                    wb_bad = 1'b1;
            end
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("circular_queue: push while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("circular_queue: pop while empty");

    a_wb_target: assert property (@(posedge clk) disable iff (rst) !wb_bad)
        else $error("circular_queue: writeback to a free or already done slot");

endmodule

// ==== rtl/rob_dispatch.sv ====
`timescale 1ns/1ps

module rob_dispatch #(
    parameter int SS    = 2,
    parameter int DEPTH = 8
) (
    input  logic                                 dispatch_valid,
    input  rob_pkg::instr_word_u                 dispatch_instr [SS],
    input  logic [31:0]                          dispatch_pc,
    input  logic                                 full,
    input  logic [rob_pkg::tag_w(DEPTH)-1:0]     head_out,
    output logic                                 dispatch_ready,
    output logic                                 push,
    output rob_pkg::rob_entry_t                  entries      [SS],
    output logic [rob_pkg::tag_w(DEPTH)-1:0]     dispatch_tag [SS]
);
    localparam int TW = rob_pkg::tag_w(DEPTH);

    logic [6:0] opc     [SS];
    logic       no_dest [SS];

    assign dispatch_ready = !full;
    assign push           = dispatch_valid && dispatch_ready;

    always_comb begin
        for (int i = 0; i < SS; i++) begin
            opc[i] = dispatch_instr[i].sb.opcode;
            // Stores and branches carry immediate bits in the rd slot
            no_dest[i] = (opc[i] == rob_pkg::OPC_STORE) || (opc[i] == rob_pkg::OPC_BRANCH);

            entries[i].pc     = dispatch_pc + 32'(4 * i);
            entries[i].rd     = dispatch_instr[i].r.rd;
            entries[i].rd_we  = !no_dest[i] && (dispatch_instr[i].r.rd != 5'd0);
            entries[i].done   = 1'b0;
            entries[i].result = '0;

            dispatch_tag[i] = head_out + TW'(i);   // Slot the member lands in
        end
    end

endmodule

// ==== rtl/rob_writeback.sv ====
`timescale 1ns/1ps

module rob_writeback #(
    parameter int WB_PORTS = 2,
    parameter int DEPTH    = 8
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [WB_PORTS-1:0]                wb_valid,
    input  logic [rob_pkg::tag_w(DEPTH)-1:0]   wb_tag    [WB_PORTS],
    input  logic [31:0]                        wb_result [WB_PORTS],
    rob_wb_if.source                           wbq
);
    logic dup_tag;

    assign wbq.valid = wb_valid;

    always_comb begin
        dup_tag = 1'b0;
        for (int i = 0; i < WB_PORTS; i++) begin
            wbq.tag[i]    = wb_tag[i];
            wbq.result[i] = wb_result[i];
            // Two units finishing the same slot in one cycle
            for (int j = i + 1; j < WB_PORTS; j++) begin
                if (wb_valid[i] && wb_valid[j] && (wb_tag[i] == wb_tag[j]))
                    dup_tag = 1'b1;
            end
        end
    end

    a_unique_tags: assert property (@(posedge clk) disable iff (rst) !dup_tag)
        else $error("rob_writeback: two writeback ports carry the same tag");

endmodule

// ==== rtl/rob_commit.sv ====
`timescale 1ns/1ps

module rob_commit #(
    parameter int SS    = 2,
    parameter int DEPTH = 8
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               empty,
    input  logic [rob_pkg::tag_w(DEPTH)-1:0]   tail_out,
    input  rob_pkg::rob_entry_t                obs_out [SS],
    input  rob_pkg::rob_entry_t                out     [SS],
    output logic [rob_pkg::tag_w(DEPTH)-1:0]   obs_sel [SS],
    output logic                               pop,
    output logic                               commit_valid,
    output logic [31:0]                        commit_pc    [SS],
    output logic [4:0]                         commit_rd    [SS],
    output logic [SS-1:0]                      commit_we,
    output logic [31:0]                        commit_value [SS]
);
    localparam int TW = rob_pkg::tag_w(DEPTH);

    logic all_done;

    // Look at the oldest group
    always_comb begin
        all_done = 1'b1;
        for (int i = 0; i < SS; i++) begin
            obs_sel[i] = tail_out + TW'(i);
            all_done   = all_done && obs_out[i].done;
        end
    end

    assign pop = !empty && all_done;   // Retire only a fully done group

    always_ff @(posedge clk) begin
        if (rst)
            commit_valid <= 1'b0;
        else
            commit_valid <= pop;   // Queue registers the group at the same edge
    end

    always_comb begin
        for (int i = 0; i < SS; i++) begin
            commit_pc[i]    = out[i].pc;
            commit_rd[i]    = out[i].rd;
            commit_we[i]    = out[i].rd_we;
            commit_value[i] = out[i].result;
        end
    end

    // Earliest commit needs a push, a writeback and a pop after reset
    a_quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !commit_valid [*2])
        else $error("rob_commit: commit_valid right after reset");

endmodule

// ==== rtl/rob_apb_status.sv ====
`timescale 1ns/1ps

module rob_apb_status #(
    parameter int DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [31:0]                paddr,
    input  logic [31:0]                pwdata,
    input  logic [$clog2(DEPTH):0]     count,
    input  logic                       empty,
    input  logic                       full,
    input  logic                       commit_valid,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr
);
    logic [31:0] commits;
    logic [31:0] status_word;
    logic        setup_phase;
    logic        clr_commits;
    logic        hit_status;
    logic        hit_commits;

    assign pready      = 1'b1;   // No wait states
    assign setup_phase = psel && !penable;
    assign hit_status  = (paddr == rob_pkg::APB_ADDR_STATUS);
    assign hit_commits = (paddr == rob_pkg::APB_ADDR_COMMITS);

    // Any written value clears the counter
    assign clr_commits = psel && penable && pwrite && hit_commits;

    assign status_word = {22'd0, full, empty, 8'(count)};

    always_ff @(posedge clk) begin
        if (rst)
            commits <= '0;
        else if (clr_commits)
            commits <= '0;
        else if (commit_valid && (commits != '1))
            commits <= commits + 32'd1;   // Saturates
    end

    // Read data is ready by the access phase
    always_ff @(posedge clk) begin
        if (rst) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else if (setup_phase) begin
            pslverr <= !(hit_status || hit_commits);
            if (pwrite)
                prdata <= '0;
            else if (hit_status)
                prdata <= status_word;
            else if (hit_commits)
                prdata <= commits;
            else
                prdata <= '0;
        end else if (!psel) begin
            pslverr <= 1'b0;
        end
    end

endmodule

// ==== rtl/rob_top.sv ====
`timescale 1ns/1ps

module rob_top #(
    parameter int SS       = 2,
    parameter int DEPTH    = 8,
    parameter int WB_PORTS = 2
) (
    input  logic                               clk,
    input  logic                               rst,

    input  logic                               dispatch_valid,
    input  rob_pkg::instr_word_u               dispatch_instr [SS],
    input  logic [31:0]                        dispatch_pc,
    output logic                               dispatch_ready,
    output logic [rob_pkg::tag_w(DEPTH)-1:0]   dispatch_tag   [SS],

    input  logic [WB_PORTS-1:0]                wb_valid,
    input  logic [rob_pkg::tag_w(DEPTH)-1:0]   wb_tag         [WB_PORTS],
    input  logic [31:0]                        wb_result      [WB_PORTS],

    output logic                               commit_valid,
    output logic [31:0]                        commit_pc      [SS],
    output logic [4:0]                         commit_rd      [SS],
    output logic [SS-1:0]                      commit_we,
    output logic [31:0]                        commit_value   [SS],

    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [31:0]                        paddr,
    input  logic [31:0]                        pwdata,
    output logic [31:0]                        prdata,
    output logic                               pready,
    output logic                               pslverr
);
    localparam int TW = rob_pkg::tag_w(DEPTH);

    logic                push, pop, empty, full;
    logic [TW-1:0]       head_out, tail_out;
    logic [TW:0]         count;
    logic [TW-1:0]       obs_sel   [SS];
    rob_pkg::rob_entry_t new_group [SS];
    rob_pkg::rob_entry_t old_group [SS];   // Registered on pop
    rob_pkg::rob_entry_t obs_out   [SS];

    rob_wb_if #(.WB_PORTS(WB_PORTS), .DEPTH(DEPTH)) wb_bus ();

    rob_dispatch #(.SS(SS), .DEPTH(DEPTH)) u_dispatch (
        .dispatch_valid (dispatch_valid),
        .dispatch_instr (dispatch_instr),
        .dispatch_pc    (dispatch_pc),
        .full           (full),
        .head_out       (head_out),
        .dispatch_ready (dispatch_ready),
        .push           (push),
        .entries        (new_group),
        .dispatch_tag   (dispatch_tag)
    );

    circular_queue #(.SS(SS), .DEPTH(DEPTH), .SEL_OUT(SS)) u_queue (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .pop      (pop),
        .in       (new_group),
        .wb       (wb_bus.sink),
        .obs_sel  (obs_sel),
        .empty    (empty),
        .full     (full),
        .head_out (head_out),
        .tail_out (tail_out),
        .count    (count),
        .out      (old_group),
        .obs_out  (obs_out)
    );

    rob_writeback #(.WB_PORTS(WB_PORTS), .DEPTH(DEPTH)) u_writeback (
        .clk       (clk),
        .rst       (rst),
        .wb_valid  (wb_valid),
        .wb_tag    (wb_tag),
        .wb_result (wb_result),
        .wbq       (wb_bus.source)
    );

    rob_commit #(.SS(SS), .DEPTH(DEPTH)) u_commit (
        .clk          (clk),
        .rst          (rst),
        .empty        (empty),
        .tail_out     (tail_out),
        .obs_out      (obs_out),
        .out          (old_group),
        .obs_sel      (obs_sel),
        .pop          (pop),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_we    (commit_we),
        .commit_value (commit_value)
    );

    rob_apb_status #(.DEPTH(DEPTH)) u_apb (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .count        (count),
        .empty        (empty),
        .full         (full),
        .commit_valid (commit_valid),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr)
    );

endmodule

// ==== sim/tb_rob_top.sv ====
`timescale 1ns/1ps

module tb_rob_top;

    localparam int  SS           = 2;
    localparam int  DEPTH        = 8;
    localparam int  WB_PORTS     = 2;
    localparam int  TW           = rob_pkg::tag_w(DEPTH);
    localparam int  NGRP         = DEPTH / SS;
    localparam int  RAND_GROUPS  = 24;
    localparam int  TOTAL_GROUPS = NGRP - 1 + RAND_GROUPS;
    localparam real CLK_PERIOD   = 8.0;

    logic                 clk;
    logic                 rst;
    logic                 dispatch_valid;
    rob_pkg::instr_word_u dispatch_instr [SS];
    logic [31:0]          dispatch_pc;
    logic                 dispatch_ready;
    logic [TW-1:0]        dispatch_tag   [SS];
    logic [WB_PORTS-1:0]  wb_valid;
    logic [TW-1:0]        wb_tag         [WB_PORTS];
    logic [31:0]          wb_result      [WB_PORTS];
    logic                 commit_valid;
    logic [31:0]          commit_pc      [SS];
    logic [4:0]           commit_rd      [SS];
    logic [SS-1:0]        commit_we;
    logic [31:0]          commit_value   [SS];
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [31:0]          paddr;
    logic [31:0]          pwdata;
    logic [31:0]          prdata;
    logic                 pready;
    logic                 pslverr;

    // Scoreboard, indexed by tag
    logic [31:0] m_pc   [DEPTH];
    logic [4:0]  m_rd   [DEPTH];
    logic        m_we   [DEPTH];
    logic        m_done [DEPTH];
    logic [31:0] m_res  [DEPTH];
    int          cplt   [NGRP];   // Cycle of the group's last writeback, -1 while pending
    int          grp_q  [$];      // Base tags of outstanding groups, oldest first
    int          model_head;
    int          cycle;
    int          last_commit;
    int          errors;
    int          commits_seen;
    int          dispatched;
    logic [31:0] next_pc;
    integer      seed;
    string       test_name;

    rob_top #(.SS(SS), .DEPTH(DEPTH), .WB_PORTS(WB_PORTS)) dut0 (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_instr (dispatch_instr),
        .dispatch_pc    (dispatch_pc),
        .dispatch_ready (dispatch_ready),
        .dispatch_tag   (dispatch_tag),
        .wb_valid       (wb_valid),
        .wb_tag         (wb_tag),
        .wb_result      (wb_result),
        .commit_valid   (commit_valid),
        .commit_pc      (commit_pc),
        .commit_rd      (commit_rd),
        .commit_we      (commit_we),
        .commit_value   (commit_value),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TOTAL_GROUPS * 40 * CLK_PERIOD + 2000.0);
        $display("Watchdog: the run did not finish in time and was stopped");
        $display("SOME TESTS FAILED");
        $finish;
    end

    a_pready_high: assert property (@(posedge clk) disable iff (rst) pready)
        else begin
            errors++;
            $display("APB slave dropped pready");
        end

    a_idle_in_reset: assert property (@(posedge clk) rst |=> !commit_valid)
        else begin
            errors++;
            $display("commit_valid was raised while in reset");
        end

    task automatic expect_value(input string field, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (exp === act) else begin
            errors++;
            $display("[ERROR] %s %s: expected 0x%08h actual 0x%08h", test_name, field, exp, act);
        end
    endtask

    // STATUS word for a given number of live entries
    function automatic logic [31:0] status_expect(input int occ);
        return {22'd0, 1'(occ + SS == DEPTH), 1'(occ == 0), 8'(occ)};
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
        dispatch_valid = 1'b0;
        wb_valid       = '0;
    endtask

    task automatic random_instr(output logic [31:0] w);
        int kind;
        kind = $unsigned($random(seed)) % 5;
        w    = $random(seed);
        case (kind)
            0: w[6:0] = 7'b0110011;   // R-type ALU
            1: w[6:0] = 7'b0010011;   // I-type ALU
            2: w[6:0] = rob_pkg::OPC_STORE;
            3: w[6:0] = rob_pkg::OPC_BRANCH;
            default: begin
                w[6:0]  = 7'b0110011;
                w[11:7] = 5'd0;       // Targets x0
            end
        endcase
    endtask

    task automatic drive_group();
        logic [31:0] w;
        for (int i = 0; i < SS; i++) begin
            random_instr(w);
            dispatch_instr[i] = rob_pkg::instr_word_u'(w);
        end
        dispatch_pc    = next_pc;
        dispatch_valid = 1'b1;
        next_pc        = next_pc + 32'(4 * SS);
    endtask

    task automatic drive_writeback(input int port, input int tag);
        wb_valid[port]  = 1'b1;
        wb_tag[port]    = TW'(tag);
        wb_result[port] = $random(seed);
    endtask

    // Sends the given tags in random order, one or two per cycle
    task automatic write_back_tags(input int tags[$]);
        int n;
        int idx;
        while (tags.size() != 0) begin
            step();
            n = 1 + ($unsigned($random(seed)) % WB_PORTS);
            for (int p = 0; p < n && tags.size() != 0; p++) begin
                idx = $unsigned($random(seed)) % tags.size();
                drive_writeback(p, tags[idx]);
                tags.delete(idx);
            end
        end
    endtask

    task automatic random_traffic(input int groups);
        int sent;
        int guard;
        int idx;
        int cand [$];
        sent  = 0;
        guard = 0;
        while ((sent < groups || dispatch_valid || grp_q.size() != 0) && guard < groups * 40) begin
            step();
            guard++;
            if (sent < groups && dispatch_ready && ($random(seed) & 1)) begin
                drive_group();
                sent++;
            end
            // Only entries already in the model may be written back
            cand.delete();
            foreach (grp_q[g]) begin
                for (int i = 0; i < SS; i++) begin
                    if (!m_done[grp_q[g] + i])
                        cand.push_back(grp_q[g] + i);
                end
            end
            for (int p = 0; p < WB_PORTS; p++) begin
                if (cand.size() != 0 && ($random(seed) & 1)) begin
                    idx = $unsigned($random(seed)) % cand.size();
                    drive_writeback(p, cand[idx]);
                    cand.delete(idx);
                end
            end
        end
        assert (sent == groups && grp_q.size() == 0) else begin
            errors++;
            $display("Random traffic stalled with %0d of %0d groups sent and %0d in flight",
                     sent, groups, grp_q.size());
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (grp_q.size() != 0 && n < limit) begin
            step();
            n++;
        end
        assert (grp_q.size() == 0) else begin
            errors++;
            $display("ROB did not drain within %0d cycles, %0d groups left", limit, grp_q.size());
        end
        repeat (2) step();
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic err);
        step();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        step();
        penable = 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        step();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                             output logic err);
        step();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        step();
        penable = 1'b1;
        @(negedge clk);
        err = pslverr;
        step();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic check_register(input logic [31:0] addr, input logic [31:0] exp,
                                  input logic exp_err);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        expect_value("pslverr", 32'(exp_err), 32'(err));
        if (!exp_err)
            expect_value("prdata", exp, data);
    endtask

    task automatic check_commit();
        int base;
        int due;
        base = -1;
        due  = -1;
        if (grp_q.size() != 0) begin
            base = grp_q[0];
            if (cplt[base / SS] >= 0) begin
                due = cplt[base / SS] + 2;   // Writeback edge, then pop edge
                if (last_commit + 1 > due)
                    due = last_commit + 1;   // One group per cycle
            end
        end
        if (commit_valid) begin
            commits_seen++;
            expect_value("commit cycle", 32'(due), 32'(cycle));
            if (base >= 0) begin
                for (int i = 0; i < SS; i++) begin
                    expect_value("commit_pc", m_pc[base + i], commit_pc[i]);
                    expect_value("commit_we", 32'(m_we[base + i]), 32'(commit_we[i]));
                    if (m_we[base + i])
                        expect_value("commit_rd", 32'(m_rd[base + i]), 32'(commit_rd[i]));
                    expect_value("commit_value", m_res[base + i], commit_value[i]);
                end
                void'(grp_q.pop_front());
                last_commit = cycle;
            end
        end else begin
            assert (due != cycle) else begin
                errors++;
                $display("Group at tag %0d was complete but did not commit on time", base);
            end
        end
    endtask

    task automatic record_writebacks();
        int   t;
        int   g;
        logic all_done;
        for (int p = 0; p < WB_PORTS; p++) begin
            if (wb_valid[p]) begin
                t         = wb_tag[p];
                m_done[t] = 1'b1;
                m_res[t]  = wb_result[p];
                g         = t / SS;
                all_done  = 1'b1;
                for (int i = 0; i < SS; i++)
                    all_done = all_done && m_done[g * SS + i];
                if (all_done)
                    cplt[g] = cycle;
            end
        end
    endtask

    task automatic record_dispatch();
        logic [31:0] w;
        int          t;
        if (dispatch_valid && dispatch_ready) begin
            for (int i = 0; i < SS; i++) begin
                t = (model_head + i) % DEPTH;
                w = dispatch_instr[i];
                expect_value("dispatch_tag", 32'(t), 32'(dispatch_tag[i]));
                m_pc[t]   = dispatch_pc + 32'(4 * i);
                m_rd[t]   = w[11:7];
                // Stores, branches and x0 targets write no register
                m_we[t]   = (w[6:0] != rob_pkg::OPC_STORE) && (w[6:0] != rob_pkg::OPC_BRANCH)
                            && (w[11:7] != 5'd0);
                m_done[t] = 1'b0;
            end
            cplt[model_head / SS] = -1;
            grp_q.push_back(model_head);
            model_head = (model_head + SS) % DEPTH;
            dispatched++;
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            cycle++;
            check_commit();
            record_writebacks();
            record_dispatch();
        end
    end

    initial begin
        int          accepted;
        int          younger [$];
        int          oldest  [$];
        logic        err;
        seed           = 32'hf2fe_d3a0;
        errors         = 0;
        commits_seen   = 0;
        dispatched     = 0;
        cycle          = 0;
        last_commit    = -10;
        model_head     = 0;
        next_pc        = 32'h0000_1000;
        test_name      = "reset";
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_pc    = '0;
        wb_valid       = '0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        for (int i = 0; i < SS; i++)
            dispatch_instr[i] = '0;
        for (int p = 0; p < WB_PORTS; p++) begin
            wb_tag[p]    = '0;
            wb_result[p] = '0;
        end
        for (int t = 0; t < DEPTH; t++) begin
            m_pc[t]   = '0;
            m_rd[t]   = '0;
            m_we[t]   = 1'b0;
            m_done[t] = 1'b0;
            m_res[t]  = '0;
        end
        for (int g = 0; g < NGRP; g++)
            cplt[g] = -1;

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        expect_value("dispatch_ready", 32'd1, 32'(dispatch_ready));
        expect_value("commit_valid", 32'd0, 32'(commit_valid));
        check_register(rob_pkg::APB_ADDR_STATUS, status_expect(0), 1'b0);
        check_register(rob_pkg::APB_ADDR_COMMITS, 32'd0, 1'b0);

        // No writebacks, so the ROB fills until the speculative full flag
        test_name = "fill";
        accepted  = 0;
        step();
        while (dispatch_ready && accepted < NGRP) begin
            drive_group();
            accepted++;
            step();
        end
        expect_value("groups accepted", 32'(NGRP - 1), 32'(accepted));
        expect_value("dispatch_ready", 32'd0, 32'(dispatch_ready));
        check_register(rob_pkg::APB_ADDR_STATUS, status_expect(grp_q.size() * SS), 1'b0);

        // Younger groups finish first, the oldest holds everything back
        test_name = "commit_order";
        for (int g = 1; g < grp_q.size(); g++) begin
            for (int i = 0; i < SS; i++)
                younger.push_back(grp_q[g] + i);
        end
        write_back_tags(younger);
        repeat (6) step();
        for (int i = 0; i < SS; i++)
            oldest.push_back(grp_q[0] + i);
        write_back_tags(oldest);
        wait_drain(20);
        check_register(rob_pkg::APB_ADDR_COMMITS, 32'(commits_seen), 1'b0);

        test_name = "random";
        random_traffic(RAND_GROUPS);
        wait_drain(20);

        test_name = "apb";
        check_register(rob_pkg::APB_ADDR_COMMITS, 32'(commits_seen), 1'b0);
        apb_write(rob_pkg::APB_ADDR_COMMITS, $random(seed), err);
        expect_value("pslverr", 32'd0, 32'(err));
        check_register(rob_pkg::APB_ADDR_COMMITS, 32'd0, 1'b0);
        check_register(rob_pkg::APB_ADDR_STATUS, status_expect(grp_q.size() * SS), 1'b0);
        check_register(32'h8, 32'd0, 1'b1);
        check_register(32'h100, 32'd0, 1'b1);

        repeat (2) step();
        $display("Summary: %0d errors, %0d groups dispatched, %0d commits seen",
                 errors, dispatched, commits_seen);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
rtl/rob_pkg.sv
rtl/rob_wb_if.sv
rtl/circular_queue.sv
rtl/rob_dispatch.sv
rtl/rob_writeback.sv
rtl/rob_commit.sv
rtl/rob_apb_status.sv
rtl/rob_top.sv
sim/tb_rob_top.sv

// ==== Bender.yml ====
package:
  name: rob

sources:
  - files:
      - rtl/rob_pkg.sv
      - rtl/rob_wb_if.sv
      - rtl/circular_queue.sv
      - rtl/rob_dispatch.sv
      - rtl/rob_writeback.sv
      - rtl/rob_commit.sv
      - rtl/rob_apb_status.sv
      - rtl/rob_top.sv
  - target: simulation
    files:
      - sim/tb_rob_top.sv
